/* verilog/mem_decoupler_pkg.sv */
package mem_decoupler_pkg;

    // AXI field widths
    localparam int ID_W   = 4;
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;
    localparam int LEN_W  = 8;

    // Outstanding limits per direction
    localparam int MAX_OUTST_TXN   = 8;
    // Worst case of 256 beats owed per accepted burst
    localparam int MAX_OUTST_BEATS = MAX_OUTST_TXN * 256;

    // Counter widths
    localparam int TXN_CNT_W  = $clog2(MAX_OUTST_TXN + 1);
    localparam int BEAT_CNT_W = $clog2(MAX_OUTST_BEATS + 1);

    // Status vector bit positions
    localparam int ST_AW = 0;
    localparam int ST_W  = 1;
    localparam int ST_B  = 2;
    localparam int ST_AR = 3;
    localparam int ST_R  = 4;

    typedef logic [ID_W-1:0]       axi_id_t;
    typedef logic [ADDR_W-1:0]     axi_addr_t;
    typedef logic [DATA_W-1:0]     axi_data_t;
    typedef logic [STRB_W-1:0]     axi_strb_t;
    typedef logic [LEN_W-1:0]      axi_len_t;
    typedef logic [2:0]            axi_size_t;
    typedef logic [1:0]            axi_burst_t;
    typedef logic [1:0]            axi_resp_t;
    typedef logic [4:0]            status_vec_t;
    typedef logic [TXN_CNT_W-1:0]  txn_cnt_t;
    typedef logic [BEAT_CNT_W-1:0] beat_cnt_t;

endpackage

/* verilog/wr_path_status_if.sv */
`timescale 1ns/10ps

interface wr_path_status_if;

    // Requests from the controller
    logic isolate;
    logic force_drain;

    // Per-channel state from the write path
    logic aw_decoupled;
    logic w_decoupled;
    logic b_decoupled;
    logic idle;

    modport ctrl (
        output isolate, force_drain,
        input  aw_decoupled, w_decoupled, b_decoupled, idle
    );

    modport path (
        input  isolate, force_drain,
        output aw_decoupled, w_decoupled, b_decoupled, idle
    );

endinterface

/* verilog/rd_path_status_if.sv */
`timescale 1ns/10ps

interface rd_path_status_if;

    // Requests from the controller
    logic isolate;
    logic force_drain;

    // State from the read path
    logic ar_decoupled;
    logic r_decoupled;
    logic idle;

    modport ctrl (
        output isolate, force_drain,
        input  ar_decoupled, r_decoupled, idle
    );

    modport path (
        input  isolate, force_drain,
        output ar_decoupled, r_decoupled, idle
    );

endinterface

/* verilog/txn_counter.sv */
`timescale 1ns/10ps

module txn_counter #(
    parameter int MAX_COUNT = 8
) (
    input  logic                           aclk,
    input  logic                           aresetn,
    input  logic                           inc,
    input  logic                           dec,
    input  logic [$clog2(MAX_COUNT+1)-1:0] inc_amount,
    output logic                           empty,
    output logic                           full
);

    localparam int CNT_W = $clog2(MAX_COUNT + 1);

    logic [CNT_W-1:0] count;
    // One extra bit so overflow shows up in the check
    logic [CNT_W:0]   add_amount;
    logic [CNT_W:0]   count_next;

    // Add and subtract may land in the same cycle
    assign add_amount = inc ? {1'b0, inc_amount} : '0;
    assign count_next = {1'b0, count} + add_amount - {{CNT_W{1'b0}}, dec};

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            count <= '0;
        end else if (inc || dec) begin
            count <= count_next[CNT_W-1:0];
        end
    end

    assign empty = (count == '0);
    assign full  = ({1'b0, count} >= (CNT_W+1)'(MAX_COUNT));

    // Nothing left to retire
    no_underflow: assert property (@(posedge aclk) disable iff (!aresetn)
        dec && !inc |-> !empty)
        else $error("txn_counter decremented while empty");

    // Caller must respect the limit
    no_overflow: assert property (@(posedge aclk) disable iff (!aresetn)
        inc |-> count_next <= (CNT_W+1)'(MAX_COUNT))
        else $error("txn_counter exceeded MAX_COUNT");

endmodule

/* verilog/wr_path_decoupler.sv */
`timescale 1ns/10ps

module wr_path_decoupler (
    input  logic                         aclk,
    input  logic                         aresetn,
    // Write address
    input  logic                         in_awvalid,
    input  mem_decoupler_pkg::axi_len_t  in_awlen,
    output logic                         in_awready,
    output logic                         out_awvalid,
    input  logic                         out_awready,
    // Write data
    input  logic                         in_wvalid,
    input  mem_decoupler_pkg::axi_strb_t in_wstrb,
    output logic                         in_wready,
    output logic                         out_wvalid,
    output mem_decoupler_pkg::axi_strb_t out_wstrb,
    input  logic                         out_wready,
    // Write response
    output logic                         in_bvalid,
    input  logic                         in_bready,
    input  logic                         out_bvalid,
    output logic                         out_bready,
    wr_path_status_if.path               status
);

    logic                         sticky_aw;
    logic                         aw_isolated;
    logic                         aw_block;
    logic                         aw_fire;
    logic                         w_block;
    logic                         w_drain;
    logic                         w_fire;
    logic                         b_fire;
    logic                         beats_empty;
    logic                         resp_empty;
    logic                         resp_full;
    mem_decoupler_pkg::beat_cnt_t beat_inc;

    // AW isolated unless a started handshake is pending
    assign aw_isolated = status.isolate && !sticky_aw;
    // Back-pressure at the outstanding limit
    assign aw_block    = aw_isolated || resp_full;
    assign out_awvalid = aw_block ? 1'b0 : in_awvalid;
    assign in_awready  = aw_block ? 1'b0 : out_awready;
    assign aw_fire     = out_awvalid && out_awready;

    // Valid seen before isolation stays up until downstream ready
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            sticky_aw <= 1'b0;
        end else if (in_awvalid && !out_awready && !status.isolate) begin
            sticky_aw <= 1'b1;
        end else if (out_awready) begin
            sticky_aw <= 1'b0;
        end
    end

    // W closes only once no beats are owed
    assign w_block = status.isolate && beats_empty;
    assign w_drain = status.force_drain && !beats_empty;

    always_comb begin
        if (w_block) begin
            out_wvalid = 1'b0;
            in_wready  = 1'b0;
            out_wstrb  = in_wstrb;
        end else if (w_drain) begin
            // Dummy beats with no bytes written
            out_wvalid = 1'b1;
            in_wready  = out_wready;
            out_wstrb  = '0;
        end else begin
            out_wvalid = in_wvalid;
            in_wready  = out_wready;
            out_wstrb  = in_wstrb;
        end
    end

    assign w_fire = out_wvalid && out_wready;

    // Responses accepted downstream under force
    assign out_bready = (status.force_drain && !resp_empty) ? 1'b1 : in_bready;
    assign in_bvalid  = out_bvalid;
    assign b_fire     = out_bvalid && out_bready;

    // Owed beats per burst
    assign beat_inc = mem_decoupler_pkg::beat_cnt_t'(in_awlen)
                    + mem_decoupler_pkg::beat_cnt_t'(1);

    txn_counter #(
        .MAX_COUNT (mem_decoupler_pkg::MAX_OUTST_BEATS)
    ) i_beat_cnt (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .inc        (aw_fire),
        .dec        (w_fire),
        .inc_amount (beat_inc),
        .empty      (beats_empty),
        .full       ()
    );

    txn_counter #(
        .MAX_COUNT (mem_decoupler_pkg::MAX_OUTST_TXN)
    ) i_resp_cnt (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .inc        (aw_fire),
        .dec        (b_fire),
        .inc_amount (mem_decoupler_pkg::txn_cnt_t'(1)),
        .empty      (resp_empty),
        .full       (resp_full)
    );

    // W and B report isolated only together with AW
    assign status.aw_decoupled = aw_isolated;
    assign status.w_decoupled  = w_block && aw_isolated;
    assign status.b_decoupled  = status.isolate && resp_empty && aw_isolated;
    assign status.idle         = beats_empty && resp_empty && !sticky_aw;

    // A started AW is never withdrawn downstream
    aw_held_until_ready: assert property (@(posedge aclk) disable iff (!aresetn)
        out_awvalid && !out_awready |=> out_awvalid)
        else $error("out_awvalid dropped before out_awready");

endmodule

/* verilog/rd_path_decoupler.sv */
`timescale 1ns/10ps

module rd_path_decoupler (
    input  logic          aclk,
    input  logic          aresetn,
    // Read address
    input  logic          in_arvalid,
    output logic          in_arready,
    output logic          out_arvalid,
    input  logic          out_arready,
    // Read data
    output logic          in_rvalid,
    input  logic          in_rready,
    input  logic          out_rvalid,
    input  logic          out_rlast,
    output logic          out_rready,
    rd_path_status_if.path status
);

    logic sticky_ar;
    logic ar_isolated;
    logic ar_block;
    logic ar_fire;
    logic r_last_fire;
    logic bursts_empty;
    logic bursts_full;

    assign ar_isolated = status.isolate && !sticky_ar;
    assign ar_block    = ar_isolated || bursts_full;
    assign out_arvalid = ar_block ? 1'b0 : in_arvalid;
    assign in_arready  = ar_block ? 1'b0 : out_arready;
    assign ar_fire     = out_arvalid && out_arready;

    // Pending AR kept alive across isolation
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            sticky_ar <= 1'b0;
        end else if (in_arvalid && !out_arready && !status.isolate) begin
            sticky_ar <= 1'b1;
        end else if (out_arready) begin
            sticky_ar <= 1'b0;
        end
    end

    // Drain read data under force
    assign out_rready  = (status.force_drain && !bursts_empty) ? 1'b1 : in_rready;
    assign in_rvalid   = out_rvalid;
    // Burst retires on its last beat
    assign r_last_fire = out_rvalid && out_rready && out_rlast;

    txn_counter #(
        .MAX_COUNT (mem_decoupler_pkg::MAX_OUTST_TXN)
    ) i_burst_cnt (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .inc        (ar_fire),
        .dec        (r_last_fire),
        .inc_amount (mem_decoupler_pkg::txn_cnt_t'(1)),
        .empty      (bursts_empty),
        .full       (bursts_full)
    );

    assign status.ar_decoupled = ar_isolated;
    assign status.r_decoupled  = status.isolate && bursts_empty;
    assign status.idle         = bursts_empty && !sticky_ar;

    // A started AR is never withdrawn downstream
    ar_held_until_ready: assert property (@(posedge aclk) disable iff (!aresetn)
        out_arvalid && !out_arready |=> out_arvalid)
        else $error("out_arvalid dropped before out_arready");

endmodule

/* verilog/decouple_ctrl.sv */
`timescale 1ns/10ps

module decouple_ctrl (
    input  logic                           decouple,
    input  logic                           decouple_force,
    output logic                           decouple_done,
    output mem_decoupler_pkg::status_vec_t decouple_status,
    wr_path_status_if.ctrl                 wr,
    rd_path_status_if.ctrl                 rd
);

    logic isolate;

    // Either request isolates new addresses
    assign isolate = decouple || decouple_force;

    assign wr.isolate     = isolate;
    assign wr.force_drain = decouple_force;
    assign rd.isolate     = isolate;
    assign rd.force_drain = decouple_force;

    // Done only for a graceful request with both paths drained
    assign decouple_done = decouple && wr.idle && rd.idle;

    assign decouple_status[mem_decoupler_pkg::ST_AW] = wr.aw_decoupled;
    assign decouple_status[mem_decoupler_pkg::ST_W]  = wr.w_decoupled;
    assign decouple_status[mem_decoupler_pkg::ST_B]  = wr.b_decoupled;
    assign decouple_status[mem_decoupler_pkg::ST_AR] = rd.ar_decoupled;
    assign decouple_status[mem_decoupler_pkg::ST_R]  = rd.r_decoupled;

    // No sticky address left once done, so every channel reads isolated
    done_all_isolated: assert final (!decouple_done || (&decouple_status))
        else $error("decouple_done raised with a channel still coupled");

endmodule

/* verilog/mem_decoupler.sv */
`timescale 1ns/10ps

module mem_decoupler (
    // Upstream write address
    input  mem_decoupler_pkg::axi_id_t     mem_in_awid,
    input  mem_decoupler_pkg::axi_addr_t   mem_in_awaddr,
    input  mem_decoupler_pkg::axi_len_t    mem_in_awlen,
    input  mem_decoupler_pkg::axi_size_t   mem_in_awsize,
    input  mem_decoupler_pkg::axi_burst_t  mem_in_awburst,
    input  logic                           mem_in_awvalid,
    output logic                           mem_in_awready,
    // Upstream write data
    input  mem_decoupler_pkg::axi_data_t   mem_in_wdata,
    input  mem_decoupler_pkg::axi_strb_t   mem_in_wstrb,
    input  logic                           mem_in_wlast,
    input  logic                           mem_in_wvalid,
    output logic                           mem_in_wready,
    // Upstream write response
    output mem_decoupler_pkg::axi_id_t     mem_in_bid,
    output mem_decoupler_pkg::axi_resp_t   mem_in_bresp,
    output logic                           mem_in_bvalid,
    input  logic                           mem_in_bready,
    // Upstream read address
    input  mem_decoupler_pkg::axi_id_t     mem_in_arid,
    input  mem_decoupler_pkg::axi_addr_t   mem_in_araddr,
    input  mem_decoupler_pkg::axi_len_t    mem_in_arlen,
    input  mem_decoupler_pkg::axi_size_t   mem_in_arsize,
    input  mem_decoupler_pkg::axi_burst_t  mem_in_arburst,
    input  logic                           mem_in_arvalid,
    output logic                           mem_in_arready,
    // Upstream read data
    output mem_decoupler_pkg::axi_id_t     mem_in_rid,
    output mem_decoupler_pkg::axi_data_t   mem_in_rdata,
    output mem_decoupler_pkg::axi_resp_t   mem_in_rresp,
    output logic                           mem_in_rlast,
    output logic                           mem_in_rvalid,
    input  logic                           mem_in_rready,
    // Downstream write address
    output mem_decoupler_pkg::axi_id_t     mem_out_awid,
    output mem_decoupler_pkg::axi_addr_t   mem_out_awaddr,
    output mem_decoupler_pkg::axi_len_t    mem_out_awlen,
    output mem_decoupler_pkg::axi_size_t   mem_out_awsize,
    output mem_decoupler_pkg::axi_burst_t  mem_out_awburst,
    output logic                           mem_out_awvalid,
    input  logic                           mem_out_awready,
    // Downstream write data
    output mem_decoupler_pkg::axi_data_t   mem_out_wdata,
    output mem_decoupler_pkg::axi_strb_t   mem_out_wstrb,
    output logic                           mem_out_wlast,
    output logic                           mem_out_wvalid,
    input  logic                           mem_out_wready,
    // Downstream write response
    input  mem_decoupler_pkg::axi_id_t     mem_out_bid,
    input  mem_decoupler_pkg::axi_resp_t   mem_out_bresp,
    input  logic                           mem_out_bvalid,
    output logic                           mem_out_bready,
    // Downstream read address
    output mem_decoupler_pkg::axi_id_t     mem_out_arid,
    output mem_decoupler_pkg::axi_addr_t   mem_out_araddr,
    output mem_decoupler_pkg::axi_len_t    mem_out_arlen,
    output mem_decoupler_pkg::axi_size_t   mem_out_arsize,
    output mem_decoupler_pkg::axi_burst_t  mem_out_arburst,
    output logic                           mem_out_arvalid,
    input  logic                           mem_out_arready,
    // Downstream read data
    input  mem_decoupler_pkg::axi_id_t     mem_out_rid,
    input  mem_decoupler_pkg::axi_data_t   mem_out_rdata,
    input  mem_decoupler_pkg::axi_resp_t   mem_out_rresp,
    input  logic                           mem_out_rlast,
    input  logic                           mem_out_rvalid,
    output logic                           mem_out_rready,
    // Decouple control and status
    input  logic                           decouple,
    input  logic                           decouple_force,
    output logic                           decouple_done,
    output mem_decoupler_pkg::status_vec_t decouple_status_vector,
    input  logic                           aclk,
    input  logic                           aresetn
);

    wr_path_status_if wr_status ();
    rd_path_status_if rd_status ();

    // Payload fields pass straight through
    assign mem_out_awid    = mem_in_awid;
    assign mem_out_awaddr  = mem_in_awaddr;
    assign mem_out_awlen   = mem_in_awlen;
    assign mem_out_awsize  = mem_in_awsize;
    assign mem_out_awburst = mem_in_awburst;
    assign mem_out_wdata   = mem_in_wdata;
    // Forced beats keep wlast from upstream
    assign mem_out_wlast   = mem_in_wlast;
    assign mem_in_bid      = mem_out_bid;
    assign mem_in_bresp    = mem_out_bresp;
    assign mem_out_arid    = mem_in_arid;
    assign mem_out_araddr  = mem_in_araddr;
    assign mem_out_arlen   = mem_in_arlen;
    assign mem_out_arsize  = mem_in_arsize;
    assign mem_out_arburst = mem_in_arburst;
    assign mem_in_rid      = mem_out_rid;
    assign mem_in_rdata    = mem_out_rdata;
    assign mem_in_rresp    = mem_out_rresp;
    assign mem_in_rlast    = mem_out_rlast;

    wr_path_decoupler i_wr_path (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .in_awvalid  (mem_in_awvalid),
        .in_awlen    (mem_in_awlen),
        .in_awready  (mem_in_awready),
        .out_awvalid (mem_out_awvalid),
        .out_awready (mem_out_awready),
        .in_wvalid   (mem_in_wvalid),
        .in_wstrb    (mem_in_wstrb),
        .in_wready   (mem_in_wready),
        .out_wvalid  (mem_out_wvalid),
        .out_wstrb   (mem_out_wstrb),
        .out_wready  (mem_out_wready),
        .in_bvalid   (mem_in_bvalid),
        .in_bready   (mem_in_bready),
        .out_bvalid  (mem_out_bvalid),
        .out_bready  (mem_out_bready),
        .status      (wr_status.path)
    );

    rd_path_decoupler i_rd_path (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .in_arvalid  (mem_in_arvalid),
        .in_arready  (mem_in_arready),
        .out_arvalid (mem_out_arvalid),
        .out_arready (mem_out_arready),
        .in_rvalid   (mem_in_rvalid),
        .in_rready   (mem_in_rready),
        .out_rvalid  (mem_out_rvalid),
        .out_rlast   (mem_out_rlast),
        .out_rready  (mem_out_rready),
        .status      (rd_status.path)
    );

    decouple_ctrl i_ctrl (
        .decouple        (decouple),
        .decouple_force  (decouple_force),
        .decouple_done   (decouple_done),
        .decouple_status (decouple_status_vector),
        .wr              (wr_status.ctrl),
        .rd              (rd_status.ctrl)
    );

endmodule

/* tb/tb_mem_decoupler.sv */
`timescale 1ns/10ps

module tb_mem_decoupler;

    localparam int TEST_CYCLES = 1400;

    logic aclk = 1'b0;
    logic aresetn;
    // Upstream master side
    mem_decoupler_pkg::axi_id_t   mem_in_awid, mem_in_arid, mem_in_bid, mem_in_rid;
    mem_decoupler_pkg::axi_addr_t mem_in_awaddr, mem_in_araddr;
    mem_decoupler_pkg::axi_len_t  mem_in_awlen, mem_in_arlen;
    mem_decoupler_pkg::axi_size_t mem_in_awsize, mem_in_arsize;
    mem_decoupler_pkg::axi_burst_t mem_in_awburst, mem_in_arburst;
    mem_decoupler_pkg::axi_data_t mem_in_wdata, mem_in_rdata;
    mem_decoupler_pkg::axi_strb_t mem_in_wstrb;
    mem_decoupler_pkg::axi_resp_t mem_in_bresp, mem_in_rresp;
    logic mem_in_awvalid, mem_in_awready, mem_in_wlast, mem_in_wvalid, mem_in_wready;
    logic mem_in_bvalid, mem_in_bready, mem_in_arvalid, mem_in_arready;
    logic mem_in_rlast, mem_in_rvalid, mem_in_rready;
    // Downstream memory side
    mem_decoupler_pkg::axi_id_t   mem_out_awid, mem_out_arid, mem_out_bid, mem_out_rid;
    mem_decoupler_pkg::axi_addr_t mem_out_awaddr, mem_out_araddr;
    mem_decoupler_pkg::axi_len_t  mem_out_awlen, mem_out_arlen;
    mem_decoupler_pkg::axi_size_t mem_out_awsize, mem_out_arsize;
    mem_decoupler_pkg::axi_burst_t mem_out_awburst, mem_out_arburst;
    mem_decoupler_pkg::axi_data_t mem_out_wdata, mem_out_rdata;
    mem_decoupler_pkg::axi_strb_t mem_out_wstrb;
    mem_decoupler_pkg::axi_resp_t mem_out_bresp, mem_out_rresp;
    logic mem_out_awvalid, mem_out_awready, mem_out_wlast, mem_out_wvalid, mem_out_wready;
    logic mem_out_bvalid, mem_out_bready, mem_out_arvalid, mem_out_arready;
    logic mem_out_rlast, mem_out_rvalid, mem_out_rready;
    logic decouple, decouple_force, decouple_done;
    mem_decoupler_pkg::status_vec_t decouple_status_vector;

    // Reference state, counted from out-side handshakes
    int   ref_beats, ref_wr_pend, ref_rd_pend;
    logic ref_aw_sticky, ref_ar_sticky;
    logic iso;
    mem_decoupler_pkg::status_vec_t exp_status;
    // Pass-through fields per channel, source side and sink side
    logic [48:0] aw_src, aw_dst, ar_src, ar_dst;
    logic [32:0] w_src, w_dst;
    logic [6:0]  b_src, b_dst;
    logic [39:0] r_src, r_dst;
    // Phase knobs for the stimulus
    logic hold_b, hold_r, hold_up, stop_w, stall_out;
    logic aw_taken, ar_taken, b_taken, r_taken;

    mem_decoupler i_mem_decoupler (.*);

    always #2 aclk = ~aclk;

    assign iso = decouple || decouple_force;

    assign aw_src = {mem_in_awid, mem_in_awaddr, mem_in_awlen, mem_in_awsize, mem_in_awburst};
    assign aw_dst = {mem_out_awid, mem_out_awaddr, mem_out_awlen, mem_out_awsize,
                     mem_out_awburst};
    assign ar_src = {mem_in_arid, mem_in_araddr, mem_in_arlen, mem_in_arsize, mem_in_arburst};
    assign ar_dst = {mem_out_arid, mem_out_araddr, mem_out_arlen, mem_out_arsize,
                     mem_out_arburst};
    assign w_src  = {mem_in_wdata, mem_in_wlast};
    assign w_dst  = {mem_out_wdata, mem_out_wlast};
    // Responses flow from the out side back in
    assign b_src  = {mem_out_bid, mem_out_bresp, mem_out_bvalid};
    assign b_dst  = {mem_in_bid, mem_in_bresp, mem_in_bvalid};
    assign r_src  = {mem_out_rid, mem_out_rdata, mem_out_rresp, mem_out_rlast, mem_out_rvalid};
    assign r_dst  = {mem_in_rid, mem_in_rdata, mem_in_rresp, mem_in_rlast, mem_in_rvalid};

    // Status bits from the channel rules
    assign exp_status = {iso && ref_rd_pend == 0, iso && !ref_ar_sticky,
        iso && ref_wr_pend == 0 && !ref_aw_sticky, iso && ref_beats == 0 && !ref_aw_sticky,
        iso && !ref_aw_sticky};

    task automatic report_mismatch(input string name, input logic [63:0] exp,
                                   input logic [63:0] act);
        $display("Mismatch in %s: expected 0x%0h, actual 0x%0h", name, exp, act);
        $display("Test failures found");
        $fatal(1, "stopping at first error");
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge aclk);
        #1;
    endtask

    always @(posedge aclk) begin
        if (!aresetn) begin
            ref_beats     <= 0;
            ref_wr_pend   <= 0;
            ref_rd_pend   <= 0;
            ref_aw_sticky <= 1'b0;
            ref_ar_sticky <= 1'b0;
        end else begin
            // AW adds len+1 beats and one response, W and B retire them
            ref_beats <= ref_beats
                + ((mem_out_awvalid && mem_out_awready) ? int'(mem_out_awlen) + 1 : 0)
                - ((mem_out_wvalid && mem_out_wready) ? 1 : 0);
            ref_wr_pend <= ref_wr_pend + int'(mem_out_awvalid && mem_out_awready)
                - int'(mem_out_bvalid && mem_out_bready);
            ref_rd_pend <= ref_rd_pend + int'(mem_out_arvalid && mem_out_arready)
                - int'(mem_out_rvalid && mem_out_rready && mem_out_rlast);
            // Address started before isolation
            if (mem_in_awvalid && !mem_out_awready && !iso)
                ref_aw_sticky <= 1'b1;
            else if (mem_out_awready)
                ref_aw_sticky <= 1'b0;
            if (mem_in_arvalid && !mem_out_arready && !iso)
                ref_ar_sticky <= 1'b1;
            else if (mem_out_arready)
                ref_ar_sticky <= 1'b0;
        end
    end

    // Upstream master and downstream responder, both random
    initial begin
        void'($urandom(14));
        forever begin
            @(posedge aclk);
            aw_taken = mem_in_awvalid && mem_in_awready;
            ar_taken = mem_in_arvalid && mem_in_arready;
            b_taken  = mem_out_bvalid && mem_out_bready;
            r_taken  = mem_out_rvalid && mem_out_rready;
            #1;
            // Addresses held until accepted
            if (!mem_in_awvalid || aw_taken) begin
                mem_in_awvalid = ($urandom % 3) != 0;
                mem_in_awlen   = $urandom % 4;
                mem_in_awid    = $urandom;
                mem_in_awaddr  = $urandom;
                mem_in_awsize  = $urandom;
                mem_in_awburst = $urandom;
            end
            if (!mem_in_arvalid || ar_taken) begin
                mem_in_arvalid = ($urandom % 3) != 0;
                mem_in_arlen   = $urandom % 4;
                mem_in_arid    = $urandom;
                mem_in_araddr  = $urandom;
                mem_in_arsize  = $urandom;
                mem_in_arburst = $urandom;
            end
            // Beats only while some are owed
            mem_in_wvalid  = !stop_w && ref_beats > 0 && ($urandom % 2);
            mem_in_wdata   = $urandom;
            mem_in_wstrb   = $urandom;
            mem_in_wlast   = $urandom;
            mem_in_bready  = !hold_up && ($urandom % 2);
            mem_in_rready  = !hold_up && ($urandom % 2);
            mem_out_awready = !stall_out && ($urandom % 2);
            mem_out_arready = !stall_out && ($urandom % 2);
            mem_out_wready  = $urandom % 2;
            if (!mem_out_bvalid || b_taken) begin
                mem_out_bvalid = !hold_b && ref_wr_pend > 0 && ($urandom % 2);
                mem_out_bid    = $urandom;
                mem_out_bresp  = $urandom;
            end
            if (!mem_out_rvalid || r_taken) begin
                mem_out_rvalid = !hold_r && ref_rd_pend > 0 && ($urandom % 2);
                mem_out_rlast  = $urandom;
                mem_out_rdata  = $urandom;
                mem_out_rid    = $urandom;
                mem_out_rresp  = $urandom;
            end
        end
    end

    // Fields always straight through
    aw_fields_chk: assert property (@(posedge aclk) disable iff (!aresetn) aw_dst == aw_src)
        else report_mismatch("aw_fields", $sampled(aw_src), $sampled(aw_dst));
    ar_fields_chk: assert property (@(posedge aclk) disable iff (!aresetn) ar_dst == ar_src)
        else report_mismatch("ar_fields", $sampled(ar_src), $sampled(ar_dst));
    w_fields_chk: assert property (@(posedge aclk) disable iff (!aresetn) w_dst == w_src)
        else report_mismatch("w_fields", $sampled(w_src), $sampled(w_dst));
    b_fields_chk: assert property (@(posedge aclk) disable iff (!aresetn) b_dst == b_src)
        else report_mismatch("b_fields", $sampled(b_src), $sampled(b_dst));
    r_fields_chk: assert property (@(posedge aclk) disable iff (!aresetn) r_dst == r_src)
        else report_mismatch("r_fields", $sampled(r_src), $sampled(r_dst));
    aw_pass_chk: assert property (@(posedge aclk) disable iff (!aresetn)
        !iso && ref_wr_pend < 8 |-> mem_out_awvalid == mem_in_awvalid
        && mem_in_awready == mem_out_awready)
        else report_mismatch("aw_pass", $sampled({mem_in_awvalid, mem_out_awready}),
                             $sampled({mem_out_awvalid, mem_in_awready}));
    ar_pass_chk: assert property (@(posedge aclk) disable iff (!aresetn)
        !iso && ref_rd_pend < 8 |-> mem_out_arvalid == mem_in_arvalid
        && mem_in_arready == mem_out_arready)
        else report_mismatch("ar_pass", $sampled({mem_in_arvalid, mem_out_arready}),
                             $sampled({mem_out_arvalid, mem_in_arready}));
    // Owed beats pass under graceful isolation too
    w_pass_chk: assert property (@(posedge aclk) disable iff (!aresetn)
        !decouple_force && (!decouple || ref_beats > 0) |-> mem_out_wvalid == mem_in_wvalid
        && mem_out_wstrb == mem_in_wstrb && mem_in_wready == mem_out_wready)
        else report_mismatch("w_pass", $sampled({mem_in_wvalid, mem_in_wstrb, mem_out_wready}),
                             $sampled({mem_out_wvalid, mem_out_wstrb, mem_in_wready}));
    resp_pass_chk: assert property (@(posedge aclk) disable iff (!aresetn)
        !decouple_force |-> mem_out_bready == mem_in_bready && mem_out_rready == mem_in_rready)
        else report_mismatch("resp_pass", $sampled({mem_in_bready, mem_in_rready}),
                             $sampled({mem_out_bready, mem_out_rready}));
    limit_chk: assert property (@(posedge aclk) disable iff (!aresetn)
        (ref_wr_pend >= 8 |-> !mem_out_awvalid && !mem_in_awready)
        and (ref_rd_pend >= 8 |-> !mem_out_arvalid && !mem_in_arready))
        else report_mismatch("limit", 0, $sampled({mem_out_awvalid, mem_in_awready,
                                                   mem_out_arvalid, mem_in_arready}));
    iso_chk: assert property (@(posedge aclk) disable iff (!aresetn)
        (iso && !ref_aw_sticky |-> !mem_out_awvalid)
        and (iso && !ref_ar_sticky |-> !mem_out_arvalid))
        else report_mismatch("isolate", 0, $sampled({mem_out_awvalid, mem_out_arvalid}));
    // Started address not withdrawn
    sticky_chk: assert property (@(posedge aclk) disable iff (!aresetn)
        (ref_aw_sticky && mem_in_awvalid && ref_wr_pend < 8 |-> mem_out_awvalid)
        and (ref_ar_sticky && mem_in_arvalid && ref_rd_pend < 8 |-> mem_out_arvalid))
        else report_mismatch("sticky", 1, $sampled({mem_out_awvalid, mem_out_arvalid}));
    force_w_chk: assert property (@(posedge aclk) disable iff (!aresetn)
        decouple_force && ref_beats > 0 |-> mem_out_wvalid && mem_out_wstrb == '0)
        else report_mismatch("force_w", 32'h1, $sampled({mem_out_wstrb, mem_out_wvalid}));
    force_resp_chk: assert property (@(posedge aclk) disable iff (!aresetn)
        (decouple_force && ref_wr_pend > 0 |-> mem_out_bready)
        and (decouple_force && ref_rd_pend > 0 |-> mem_out_rready))
        else report_mismatch("force_resp", 3, $sampled({mem_out_bready, mem_out_rready}));
    done_chk: assert property (@(posedge aclk) disable iff (!aresetn)
        decouple_done == (decouple && ref_beats == 0 && ref_wr_pend == 0
        && ref_rd_pend == 0 && !ref_aw_sticky && !ref_ar_sticky))
        else report_mismatch("done", !$sampled(decouple_done), $sampled(decouple_done));
    status_chk: assert property (@(posedge aclk) disable iff (!aresetn)
        decouple_status_vector == exp_status)
        else report_mismatch("status", $sampled(exp_status),
                             $sampled(decouple_status_vector));

    initial begin
        #(TEST_CYCLES * 20 * 4);
        $display("Error: watchdog timeout, the run did not finish in time");
        $display("Test failures found");
        $fatal(1, "timeout");
    end

    initial begin
        {mem_in_awid, mem_in_awaddr, mem_in_awlen, mem_in_awvalid} = '0;
        {mem_in_arid, mem_in_araddr, mem_in_arlen, mem_in_arvalid} = '0;
        {mem_in_wdata, mem_in_wstrb, mem_in_wlast, mem_in_wvalid} = '0;
        {mem_in_awsize, mem_in_awburst, mem_in_arsize, mem_in_arburst} = '0;
        {mem_in_bready, mem_in_rready, mem_out_awready, mem_out_arready} = '0;
        {mem_out_wready, mem_out_bvalid, mem_out_bid, mem_out_bresp} = '0;
        {mem_out_rvalid, mem_out_rlast, mem_out_rdata, mem_out_rid, mem_out_rresp} = '0;
        {decouple, decouple_force, hold_b, hold_r, hold_up, stop_w, stall_out} = '0;
        aresetn = 1'b0;
        wait_cycles(3);
        aresetn = 1'b1;
        wait_cycles(300);
        // Starve responses to hit the limit
        {hold_b, hold_r} = 2'b11;
        wait_cycles(60);
        {hold_b, hold_r} = 2'b00;
        wait_cycles(100);
        // Stalled addresses across the decouple edge
        stall_out = 1'b1;
        wait_cycles(3);
        decouple = 1'b1;
        wait_cycles(5);
        stall_out = 1'b0;
        while (!decouple_done) wait_cycles(1);
        wait_cycles(20);
        decouple = 1'b0;
        wait_cycles(100);
        // Forced drain with upstream silent
        {hold_up, stop_w, decouple_force} = 3'b111;
        wait_cycles(80);
        decouple = 1'b1;
        while (!decouple_done) wait_cycles(1);
        wait_cycles(10);
        {hold_up, stop_w, decouple_force, decouple} = '0;
        wait_cycles(200);
        $display("All tests passed!");
        $finish;
    end

endmodule

/* mem_decoupler.f */
verilog/mem_decoupler_pkg.sv
verilog/wr_path_status_if.sv
verilog/rd_path_status_if.sv
verilog/txn_counter.sv
verilog/wr_path_decoupler.sv
verilog/rd_path_decoupler.sv
verilog/decouple_ctrl.sv
verilog/mem_decoupler.sv
tb/tb_mem_decoupler.sv

/* Bender.yml */
package:
  name: mem_decoupler

sources:
  - verilog/mem_decoupler_pkg.sv
  - verilog/wr_path_status_if.sv
  - verilog/rd_path_status_if.sv
  - verilog/txn_counter.sv
  - verilog/wr_path_decoupler.sv
  - verilog/rd_path_decoupler.sv
  - verilog/decouple_ctrl.sv
  - verilog/mem_decoupler.sv
  - target: test
    files:
      - tb/tb_mem_decoupler.sv
